/* common/standby_pkg.sv */
// Shared widths, RX descriptor layout and engine states; byte count is 16 bits, bits 30..23 stay zero
package standby_pkg;

  localparam int RX_DESC_W     = 32;
  localparam int RX_DATA_W     = 8;
  localparam int TGT_ADDR_W    = 7;
  localparam int DESC_CNT_W    = 16;
  localparam int DESC_ADDR_LSB = 16;
  localparam int DESC_ERR_BIT  = 31;

  typedef logic [RX_DESC_W-1:0]  rx_desc_t;
  typedef logic [RX_DATA_W-1:0]  rx_data_t;
  typedef logic [TGT_ADDR_W-1:0] tgt_addr_t;

  // Receive engine states, WAIT_Q is only reached by the I2C engine
  typedef enum logic [2:0] {
    IDLE,
    ADDR,
    ADDR_ACK,
    DATA,
    DATA_END,
    WAIT_Q,
    IGNORE
  } tgt_state_e;

  // Build an RX descriptor from count, address and error flag
  function automatic rx_desc_t pack_rx_desc(input logic [DESC_CNT_W-1:0] cnt,
                                            input tgt_addr_t addr,
                                            input logic err);
    rx_desc_t desc;
    desc = '0;
    desc[DESC_CNT_W-1:0] = cnt;
    desc[DESC_ADDR_LSB +: TGT_ADDR_W] = addr;
    desc[DESC_ERR_BIT] = err;
    return desc;
  endfunction

endpackage

/* standby/bus_condition_detect.sv */
// Pin changes reach all outputs exactly 3 clocks later; SCL high and low phases need 8+ clocks
`timescale 1ns/1ps

module bus_condition_detect (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic scl_i,
  input  logic sda_i,
  output logic scl_rise_o,
  output logic scl_fall_o,
  output logic start_o,
  output logic stop_o,
  output logic sda_o
);

  logic [1:0] scl_sync;
  logic [1:0] sda_sync;
  logic       scl_prev;
  logic       sda_prev;

  // Idle bus is high, so sync chains reset to 1
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      scl_sync   <= 2'b11;
      sda_sync   <= 2'b11;
      scl_prev   <= 1'b1;
      sda_prev   <= 1'b1;
      scl_rise_o <= 1'b0;
      scl_fall_o <= 1'b0;
      start_o    <= 1'b0;
      stop_o     <= 1'b0;
    end else begin
      scl_sync   <= {scl_sync[0], scl_i};
      sda_sync   <= {sda_sync[0], sda_i};
      scl_prev   <= scl_sync[1];
      sda_prev   <= sda_sync[1];
      scl_rise_o <= scl_sync[1] & ~scl_prev;
      scl_fall_o <= ~scl_sync[1] & scl_prev;
      // SDA edge with SCL high on both samples
      start_o    <= scl_sync[1] & scl_prev & sda_prev & ~sda_sync[1];
      stop_o     <= scl_sync[1] & scl_prev & ~sda_prev & sda_sync[1];
    end
  end

  // Aligned with the edge pulses
  assign sda_o = sda_prev;

  a_scl_min_phase: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (scl_rise_o || scl_fall_o) |=> !(scl_rise_o || scl_fall_o) [*7]
  ) else $error("SCL phase shorter than 8 clocks");

endmodule

/* standby/standby_i2c_target.sv */
// Private writes only; stretches SCL while a byte waits for the RX queue, descriptor error is always 0
`timescale 1ns/1ps

module standby_i2c_target (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  scl_i,
  input  logic                  sda_i,
  input  logic                  en_i,
  input  standby_pkg::tgt_addr_t target_addr_i,
  output logic                  scl_o,
  output logic                  sda_o,
  output logic                  rx_queue_wvalid_o,
  output standby_pkg::rx_data_t rx_queue_wdata_o,
  input  logic                  rx_queue_wready_i,
  output logic                  rx_desc_queue_wvalid_o,
  output standby_pkg::rx_desc_t rx_desc_queue_wdata_o,
  input  logic                  rx_desc_queue_wready_i
);
  import standby_pkg::*;

  tgt_state_e            state;
  logic            [2:0] bit_cnt;
  logic [DESC_CNT_W-1:0] byte_cnt;
  logic            [7:0] shift;
  logic                  ack_drv, addressed;
  logic                  rx_wvalid, desc_wvalid, desc_pend;
  rx_data_t              rx_data;
  rx_desc_t              desc_data;
  logic                  scl_rise, scl_fall, start, stop, sda_s;
  logic                  rx_hs, push, desc_load;

  bus_condition_detect u_detect (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .scl_i     (scl_i),
    .sda_i     (sda_i),
    .scl_rise_o(scl_rise),
    .scl_fall_o(scl_fall),
    .start_o   (start),
    .stop_o    (stop),
    .sda_o     (sda_s)
  );

  assign rx_hs     = rx_wvalid & rx_queue_wready_i;
  // 9th SCL rise with ACK on the bus
  assign push      = scl_rise & (state == DATA_END) & ack_drv;
  // Descriptor waits for the last byte to drain
  assign desc_load = desc_pend & ~rx_wvalid & ~desc_wvalid;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i || !en_i) begin
      state       <= IDLE;
      bit_cnt     <= '0;
      byte_cnt    <= '0;
      ack_drv     <= 1'b0;
      addressed   <= 1'b0;
      rx_wvalid   <= 1'b0;
      desc_wvalid <= 1'b0;
      desc_pend   <= 1'b0;
    end else begin
      if (rx_hs) begin
        rx_wvalid <= 1'b0;
        byte_cnt  <= byte_cnt + 1'b1;
      end
      if (push) rx_wvalid <= 1'b1;
      if (desc_wvalid && rx_desc_queue_wready_i) desc_wvalid <= 1'b0;
      if (desc_load) begin
        desc_wvalid <= 1'b1;
        desc_pend   <= 1'b0;
        byte_cnt    <= '0;
      end
      if (start || stop) begin
        if (addressed) desc_pend <= 1'b1;
        addressed <= 1'b0;
        ack_drv   <= 1'b0;
        bit_cnt   <= '0;
        state     <= start ? ADDR : IDLE;
      end else begin
        case (state)
          ADDR, DATA: if (scl_rise) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) begin
              if (state == DATA) begin
                state <= DATA_END;
              end else if (shift[6:0] == target_addr_i && !sda_s) begin
                state     <= ADDR_ACK;
                addressed <= 1'b1;
              end else begin
                state <= IGNORE;
              end
            end
          end
          ADDR_ACK, DATA_END: if (scl_fall) begin
            if (!ack_drv) begin
              ack_drv <= 1'b1;
              // Previous byte still pending, stretch
              if (state == DATA_END && rx_wvalid) state <= WAIT_Q;
            end else begin
              ack_drv <= 1'b0;
              state   <= DATA;
            end
          end
          WAIT_Q: if (!rx_wvalid) state <= DATA_END;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (scl_rise && (state == ADDR || state == DATA)) shift <= {shift[6:0], sda_s};
    if (push) rx_data <= shift;
    if (desc_load) desc_data <= pack_rx_desc(byte_cnt, target_addr_i, 1'b0);
  end

  assign scl_o                  = (state != WAIT_Q);
  assign sda_o                  = ~ack_drv;
  assign rx_queue_wvalid_o      = rx_wvalid;
  assign rx_queue_wdata_o       = rx_data;
  assign rx_desc_queue_wvalid_o = desc_wvalid;
  assign rx_desc_queue_wdata_o  = desc_data;

  a_rx_hold: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    en_i && rx_wvalid && !rx_queue_wready_i |=> rx_wvalid && $stable(rx_data)
  ) else $error("RX byte dropped or changed before wready");

endmodule

/* standby/standby_i3c_target.sv */
// SDR private writes only; no clock stretch, so a byte finished while one is pending is dropped
`timescale 1ns/1ps

module standby_i3c_target (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  scl_i,
  input  logic                  sda_i,
  input  logic                  en_i,
  input  standby_pkg::tgt_addr_t target_addr_i,
  output logic                  sda_o,
  output logic                  rx_queue_wvalid_o,
  output standby_pkg::rx_data_t rx_queue_wdata_o,
  output logic                  rx_queue_wflush_o,
  input  logic                  rx_queue_wready_i,
  output logic                  rx_desc_queue_wvalid_o,
  output standby_pkg::rx_desc_t rx_desc_queue_wdata_o,
  input  logic                  rx_desc_queue_wready_i
);
  import standby_pkg::*;

  tgt_state_e            state;
  logic            [2:0] bit_cnt;
  logic [DESC_CNT_W-1:0] byte_cnt;
  logic            [7:0] shift;
  logic                  ack_drv, addressed, err;
  logic                  rx_wvalid, rx_flush, flush_pend;
  logic                  desc_wvalid, desc_pend;
  rx_data_t              rx_data;
  rx_desc_t              desc_data;
  logic                  scl_rise, scl_fall, start, stop, sda_s;
  logic                  rx_hs, tbit_evt, tbit_ok, push, flush_go, desc_load;

  bus_condition_detect u_detect (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .scl_i     (scl_i),
    .sda_i     (sda_i),
    .scl_rise_o(scl_rise),
    .scl_fall_o(scl_fall),
    .start_o   (start),
    .stop_o    (stop),
    .sda_o     (sda_s)
  );

  assign rx_hs     = rx_wvalid & rx_queue_wready_i;
  assign tbit_evt  = scl_rise & (state == DATA_END);
  // Odd parity over data byte plus T-bit
  assign tbit_ok   = ^{shift, sda_s};
  assign push      = tbit_evt & tbit_ok & ~rx_wvalid;
  // Flush only once the queue port is idle
  assign flush_go  = flush_pend & ~rx_wvalid;
  assign desc_load = desc_pend & ~rx_wvalid & ~flush_pend & ~desc_wvalid;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i || !en_i) begin
      state       <= IDLE;
      bit_cnt     <= '0;
      byte_cnt    <= '0;
      ack_drv     <= 1'b0;
      addressed   <= 1'b0;
      err         <= 1'b0;
      rx_wvalid   <= 1'b0;
      rx_flush    <= 1'b0;
      flush_pend  <= 1'b0;
      desc_wvalid <= 1'b0;
      desc_pend   <= 1'b0;
    end else begin
      rx_flush <= flush_go;
      if (rx_hs) begin
        rx_wvalid <= 1'b0;
        byte_cnt  <= byte_cnt + 1'b1;
      end
      if (push) rx_wvalid <= 1'b1;
      // Flushed bytes leave the count
      if (flush_go) begin
        flush_pend <= 1'b0;
        byte_cnt   <= '0;
      end
      if (desc_wvalid && rx_desc_queue_wready_i) desc_wvalid <= 1'b0;
      if (desc_load) begin
        desc_wvalid <= 1'b1;
        desc_pend   <= 1'b0;
        byte_cnt    <= '0;
        err         <= 1'b0;
      end
      if (start || stop) begin
        if (addressed) desc_pend <= 1'b1;
        addressed <= 1'b0;
        ack_drv   <= 1'b0;
        bit_cnt   <= '0;
        state     <= start ? ADDR : IDLE;
      end else begin
        case (state)
          ADDR, DATA: if (scl_rise) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) begin
              if (state == DATA) begin
                state <= DATA_END;
              end else if (shift[6:0] == target_addr_i && !sda_s) begin
                state     <= ADDR_ACK;
                addressed <= 1'b1;
              end else begin
                state <= IGNORE;
              end
            end
          end
          ADDR_ACK: if (scl_fall) begin
            ack_drv <= ~ack_drv;
            if (ack_drv) state <= DATA;
          end
          DATA_END: if (tbit_evt) begin
            if (!tbit_ok) begin
              state      <= IGNORE;
              flush_pend <= 1'b1;
              err        <= 1'b1;
            end else begin
              state <= DATA;
              // Pending byte blocks this one
              if (rx_wvalid) err <= 1'b1;
            end
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (scl_rise && (state == ADDR || state == DATA)) shift <= {shift[6:0], sda_s};
    if (push) rx_data <= shift;
    if (desc_load) desc_data <= pack_rx_desc(byte_cnt, target_addr_i, err);
  end

  assign sda_o                  = ~ack_drv;
  assign rx_queue_wvalid_o      = rx_wvalid;
  assign rx_queue_wdata_o       = rx_data;
  assign rx_queue_wflush_o      = rx_flush & en_i;
  assign rx_desc_queue_wvalid_o = desc_wvalid;
  assign rx_desc_queue_wdata_o  = desc_data;

  a_flush_excl: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) !(rx_flush && rx_wvalid)
  ) else $error("wflush raised with wvalid");

endmodule

/* standby/standby_controller.sv */
// I3C wins when either I3C enable is set; the idle engine sees no wready and is held in reset state
`timescale 1ns/1ps

module standby_controller (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   i2c_scl_i,
  input  logic                   i2c_sda_i,
  input  logic                   i3c_scl_i,
  input  logic                   i3c_sda_i,
  output logic                   i2c_scl_o,
  output logic                   i2c_sda_o,
  output logic                   i3c_sda_o,
  input  logic                   i2c_active_en_i,
  input  logic                   i2c_standby_en_i,
  input  logic                   i3c_active_en_i,
  input  logic                   i3c_standby_en_i,
  input  standby_pkg::tgt_addr_t target_addr_i,
  output logic                   rx_queue_wvalid_o,
  output standby_pkg::rx_data_t  rx_queue_wdata_o,
  output logic                   rx_queue_wflush_o,
  input  logic                   rx_queue_wready_i,
  output logic                   rx_desc_queue_wvalid_o,
  output standby_pkg::rx_desc_t  rx_desc_queue_wdata_o,
  input  logic                   rx_desc_queue_wready_i
);
  import standby_pkg::*;

  logic     sel_i3c;
  logic     i2c_en, i3c_en;
  logic     i2c_rx_wvalid, i3c_rx_wvalid, i3c_rx_wflush;
  logic     i2c_desc_wvalid, i3c_desc_wvalid;
  rx_data_t i2c_rx_wdata, i3c_rx_wdata;
  rx_desc_t i2c_desc_wdata, i3c_desc_wdata;

  assign sel_i3c = i3c_active_en_i | i3c_standby_en_i;
  assign i3c_en  = sel_i3c;
  assign i2c_en  = ~sel_i3c & (i2c_active_en_i | i2c_standby_en_i);

  standby_i2c_target u_i2c (
    .clk_i                 (clk_i),
    .rst_n_i               (rst_n_i),
    .scl_i                 (i2c_scl_i),
    .sda_i                 (i2c_sda_i),
    .en_i                  (i2c_en),
    .target_addr_i         (target_addr_i),
    .scl_o                 (i2c_scl_o),
    .sda_o                 (i2c_sda_o),
    .rx_queue_wvalid_o     (i2c_rx_wvalid),
    .rx_queue_wdata_o      (i2c_rx_wdata),
    .rx_queue_wready_i     (rx_queue_wready_i & ~sel_i3c),
    .rx_desc_queue_wvalid_o(i2c_desc_wvalid),
    .rx_desc_queue_wdata_o (i2c_desc_wdata),
    .rx_desc_queue_wready_i(rx_desc_queue_wready_i & ~sel_i3c)
  );

  standby_i3c_target u_i3c (
    .clk_i                 (clk_i),
    .rst_n_i               (rst_n_i),
    .scl_i                 (i3c_scl_i),
    .sda_i                 (i3c_sda_i),
    .en_i                  (i3c_en),
    .target_addr_i         (target_addr_i),
    .sda_o                 (i3c_sda_o),
    .rx_queue_wvalid_o     (i3c_rx_wvalid),
    .rx_queue_wdata_o      (i3c_rx_wdata),
    .rx_queue_wflush_o     (i3c_rx_wflush),
    .rx_queue_wready_i     (rx_queue_wready_i & sel_i3c),
    .rx_desc_queue_wvalid_o(i3c_desc_wvalid),
    .rx_desc_queue_wdata_o (i3c_desc_wdata),
    .rx_desc_queue_wready_i(rx_desc_queue_wready_i & sel_i3c)
  );

  // I2C engine has no flush
  always_comb begin
    rx_queue_wvalid_o      = sel_i3c ? i3c_rx_wvalid : i2c_rx_wvalid;
    rx_queue_wdata_o       = sel_i3c ? i3c_rx_wdata : i2c_rx_wdata;
    rx_queue_wflush_o      = sel_i3c & i3c_rx_wflush;
    rx_desc_queue_wvalid_o = sel_i3c ? i3c_desc_wvalid : i2c_desc_wvalid;
    rx_desc_queue_wdata_o  = sel_i3c ? i3c_desc_wdata : i2c_desc_wdata;
  end

  // Disabled engine clears one clock after a mode change
  a_idle_engine_quiet: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    $stable(sel_i3c) |->
      (sel_i3c ? !(i2c_rx_wvalid || i2c_desc_wvalid) : !(i3c_rx_wvalid || i3c_desc_wvalid))
  ) else $error("Unselected engine raised wvalid");

endmodule

/* verif/standby_bus_tasks.svh */
// Bus master tasks for the testbench; SCL phases are PH clocks, stretch waits time out after 500
`ifndef STANDBY_BUS_TASKS_SVH
`define STANDBY_BUS_TASKS_SVH

localparam int PH = 10;

task automatic wait_clks(input int n);
  repeat (n) @(posedge clk);
endtask

// Waits while a target holds SCL low
task automatic wait_scl_high();
  int t;
  t = 0;
  @(posedge clk);
  while (!line_scl && t < 500) begin
    @(posedge clk);
    t++;
  end
  if (t >= 500) begin
    $display("Timeout: SCL was held low and never released");
    timeouts++;
  end
endtask

task automatic bus_start();
  @(posedge clk);
  m_sda <= 1'b1;
  m_scl <= 1'b1;
  wait_clks(PH);
  m_sda <= 1'b0;
  wait_clks(PH);
  m_scl <= 1'b0;
  wait_clks(PH);
endtask

task automatic bus_stop();
  @(posedge clk);
  m_sda <= 1'b0;
  wait_clks(PH);
  m_scl <= 1'b1;
  wait_scl_high();
  wait_clks(PH);
  m_sda <= 1'b1;
  wait_clks(PH);
endtask

// One SCL pulse, SDA sampled mid high phase
task automatic clock_bit(input logic b, output logic s);
  @(posedge clk);
  m_sda <= b;
  wait_clks(PH);
  m_scl <= 1'b1;
  wait_scl_high();
  wait_clks(PH / 2);
  s = line_sda;
  wait_clks(PH / 2);
  m_scl <= 1'b0;
endtask

// Eight data bits then ACK slot or T-bit
task automatic send_byte(input logic [7:0] b, input logic ninth, output logic s9);
  logic s;
  for (int i = 7; i >= 0; i--) begin
    clock_bit(b[i], s);
  end
  clock_bit(ninth, s9);
endtask

`endif

/* verif/standby_tb.sv */
// Drives both buses through a fixed row table; bytes per row are random from seed 28117
`timescale 1ns/1ps

module standby_tb;
  import standby_pkg::*;

  typedef struct packed {
    logic       mode;
    logic       bus;
    logic [6:0] addr;
    logic [2:0] nbytes;
    logic [2:0] corrupt;
    logic       hold;
    logic       exp_ack;
  } row_t;

  // mode/bus 0 is I2C, 1 is I3C; corrupt 7 means no bad T-bit
  localparam int NROWS = 10;
  localparam row_t ROWS [NROWS] = '{
    '{1'b0, 1'b0, 7'h2A, 3'd4, 3'd7, 1'b0, 1'b1},
    '{1'b0, 1'b0, 7'h15, 3'd2, 3'd7, 1'b0, 1'b0},
    '{1'b0, 1'b0, 7'h2A, 3'd3, 3'd7, 1'b1, 1'b1},
    '{1'b1, 1'b1, 7'h2A, 3'd4, 3'd7, 1'b0, 1'b1},
    '{1'b1, 1'b1, 7'h15, 3'd2, 3'd7, 1'b0, 1'b0},
    '{1'b1, 1'b1, 7'h2A, 3'd3, 3'd7, 1'b1, 1'b1},
    '{1'b1, 1'b1, 7'h2A, 3'd3, 3'd1, 1'b0, 1'b1},
    '{1'b0, 1'b1, 7'h2A, 3'd2, 3'd7, 1'b0, 1'b0},
    '{1'b1, 1'b0, 7'h2A, 3'd2, 3'd7, 1'b0, 1'b0},
    '{1'b0, 1'b0, 7'h2A, 3'd1, 3'd7, 1'b0, 1'b1}
  };
  localparam tgt_addr_t OWN_ADDR = 7'h2A;

  logic      clk;
  logic      rst_n = 1'b0;
  logic      m_scl = 1'b1;
  logic      m_sda = 1'b1;
  logic      bus = 1'b0;
  logic      hold = 1'b0;
  logic      i2c_act = 1'b0;
  logic      i2c_stby = 1'b0;
  logic      i3c_act = 1'b0;
  logic      i3c_stby = 1'b0;
  tgt_addr_t tgt_addr = OWN_ADDR;
  logic      rx_ready = 1'b0;
  logic      desc_ready = 1'b0;
  logic      i2c_scl_o, i2c_sda_o, i3c_sda_o;
  logic      rx_wvalid, rx_wflush, desc_wvalid;
  rx_data_t  rx_wdata;
  rx_desc_t  desc_wdata;
  logic      line_scl, line_sda;

  int        errors = 0;
  int        checks = 0;
  int        timeouts = 0;
  int        flush_cnt = 0;
  int        stretch_cnt = 0;
  rx_data_t  byte_q[$];
  rx_desc_t  desc_q[$];

  // Open-drain wired AND of master and DUT
  assign line_scl = m_scl & (bus ? 1'b1 : i2c_scl_o);
  assign line_sda = m_sda & (bus ? i3c_sda_o : i2c_sda_o);

  standby_controller u_standby_controller (
    .clk_i                 (clk),
    .rst_n_i               (rst_n),
    .i2c_scl_i             (bus ? 1'b1 : line_scl),
    .i2c_sda_i             (bus ? 1'b1 : line_sda),
    .i3c_scl_i             (bus ? line_scl : 1'b1),
    .i3c_sda_i             (bus ? line_sda : 1'b1),
    .i2c_scl_o             (i2c_scl_o),
    .i2c_sda_o             (i2c_sda_o),
    .i3c_sda_o             (i3c_sda_o),
    .i2c_active_en_i       (i2c_act),
    .i2c_standby_en_i      (i2c_stby),
    .i3c_active_en_i       (i3c_act),
    .i3c_standby_en_i      (i3c_stby),
    .target_addr_i         (tgt_addr),
    .rx_queue_wvalid_o     (rx_wvalid),
    .rx_queue_wdata_o      (rx_wdata),
    .rx_queue_wflush_o     (rx_wflush),
    .rx_queue_wready_i     (rx_ready),
    .rx_desc_queue_wvalid_o(desc_wvalid),
    .rx_desc_queue_wdata_o (desc_wdata),
    .rx_desc_queue_wready_i(desc_ready)
  );

  `include "standby_bus_tasks.svh"

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // While held, ready only answers a clock stretch
  always @(posedge clk) begin
    rx_ready   <= hold ? !i2c_scl_o : ($urandom % 4 != 0);
    desc_ready <= ($urandom % 3 != 0);
  end

  // Queue sinks
  always @(posedge clk) begin
    if (rx_wvalid && rx_ready) byte_q.push_back(rx_wdata);
    if (rx_wflush) begin
      flush_cnt++;
      byte_q.delete();
    end
    if (desc_wvalid && desc_ready) desc_q.push_back(desc_wdata);
    if (!i2c_scl_o) stretch_cnt++;
  end

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  initial begin
    #(20ns * 400000);
    $display("Watchdog expired before the test sequence finished");
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    int        seed;
    int        t;
    int        exp_n;
    int        stretch_base;
    logic      ack;
    logic      s9;
    logic      tbit;
    logic      exp_err;
    logic      exp_flush;
    logic      [31:0] exp_desc;
    rx_data_t  data [4];
    row_t      r;

    seed = $urandom(28117);
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    wait_clks(5);
    for (int k = 0; k < NROWS; k++) begin
      r = ROWS[k];
      // Alternate active and standby enables across rows
      i2c_act  <= !r.mode && (k % 2 == 1);
      i2c_stby <= !r.mode && (k % 2 == 0);
      i3c_act  <= r.mode && (k % 2 == 1);
      i3c_stby <= r.mode && (k % 2 == 0);
      bus      <= r.bus;
      wait_clks(5);
      byte_q.delete();
      desc_q.delete();
      flush_cnt = 0;
      for (int i = 0; i < 4; i++) data[i] = rx_data_t'($urandom);

      // Expected results from the transfer rules
      exp_n     = r.exp_ack ? int'(r.nbytes) : 0;
      exp_err   = 1'b0;
      exp_flush = 1'b0;
      if (r.exp_ack && r.bus && r.corrupt < r.nbytes) begin
        exp_n     = 0;
        exp_err   = 1'b1;
        exp_flush = 1'b1;
      end else if (r.exp_ack && r.bus && r.hold) begin
        exp_n   = 1;
        exp_err = (r.nbytes > 1);
      end
      exp_desc = (32'(exp_err) << DESC_ERR_BIT) | (32'(r.addr) << DESC_ADDR_LSB) |
                 32'(exp_n);

      stretch_base = stretch_cnt;
      hold <= r.hold;
      bus_start();
      send_byte({r.addr, 1'b0}, 1'b1, ack);
      check_val("address ack on sda", ack, !r.exp_ack);
      for (int i = 0; i < int'(r.nbytes); i++) begin
        if (r.bus) begin
          tbit = ~^data[i];
          if (i == int'(r.corrupt)) tbit = ~tbit;
          send_byte(data[i], tbit, s9);
        end else begin
          send_byte(data[i], 1'b1, s9);
          if (r.exp_ack) check_val("data ack on i2c_sda_o", s9, 1'b0);
        end
      end
      bus_stop();
      hold <= 1'b0;

      if (r.exp_ack) begin
        t = 0;
        while (desc_q.size() == 0 && t < 3000) begin
          @(posedge clk);
          t++;
        end
        if (t >= 3000) begin
          $display("Timeout: no RX descriptor arrived for row %0d", k);
          timeouts++;
        end
      end
      wait_clks(50);

      check_val("rx_queue_wdata_o count", byte_q.size(), exp_n);
      for (int i = 0; i < exp_n && i < byte_q.size(); i++) begin
        check_val("rx_queue_wdata_o", byte_q[i], data[i]);
      end
      check_val("rx_desc_queue_wvalid_o count", desc_q.size(), r.exp_ack);
      if (r.exp_ack && desc_q.size() > 0) check_val("rx_desc_queue_wdata_o", desc_q[0], exp_desc);
      check_val("rx_queue_wflush_o pulses", flush_cnt, exp_flush);
      if (r.hold && !r.bus) check_val("i2c_scl_o stretch seen", stretch_cnt > stretch_base, 1);
    end

    $display("checks=%0d errors=%0d timeouts=%0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* files.f */
+incdir+verif
common/standby_pkg.sv
standby/bus_condition_detect.sv
standby/standby_i2c_target.sv
standby/standby_i3c_target.sv
standby/standby_controller.sv
verif/standby_tb.sv

/* Makefile */
all: run

build:
	verilator --binary --timing -Wno-fatal --top-module standby_tb -f files.f -o Vstandby_tb

run: build
	./obj_dir/Vstandby_tb | tee sim.log
	@if grep -q "SOME TESTS FAILED" sim.log; then exit 1; fi
	@grep -q "ALL TESTS PASSED" sim.log

lint:
	verilator --lint-only -Wall --top-module standby_controller \
		common/standby_pkg.sv standby/bus_condition_detect.sv \
		standby/standby_i2c_target.sv standby/standby_i3c_target.sv \
		standby/standby_controller.sv

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
